// ==== rtl/access_tracker.sv ====
`timescale 1ns/1ps
// Page access tracker
// Physical page index register with per-page used and dirty bits.
// Bus requests mark pages; explicit writes load index and flags
module access_tracker (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_bus_req,        // Bus request strobe
    input  mmu_pkg::bus_opc_t i_bus_opc,        // Opcode of that request
    input  mmu_pkg::page_t    i_frame,          // Translated frame
    input  logic              i_index_we,       // Load page index
    input  mmu_pkg::page_t    i_index_data,
    input  logic              i_flags_we,       // Write flags at current index
    input  logic [1:0]        i_flags_data,     // Bit 1 dirty, bit 0 used
    output mmu_pkg::page_t    o_pg_index,
    output logic [2:0]        o_access          // Dirty, used, zero
);
    import mmu_pkg::*;

    page_t                pg_index;             // Physical page register
    logic [NUM_PAGES-1:0] pg_used;              // Page was referenced
    logic [NUM_PAGES-1:0] pg_dirty;             // Page was modified
    logic                 dirtying;             // Opcode writes memory

    //--------------------------------------------------
    // Opcode decode
    //--------------------------------------------------
    always_comb begin
        case (i_bus_opc)
            OPC_CCWR,
            OPC_DCWR,
            OPC_DWR,
            OPC_RDMWR,
            OPC_BTRWR: dirtying = 1'b1;
            default:   dirtying = 1'b0;
        endcase
    end

    //--------------------------------------------------
    // Page index register
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pg_index <= '0;
        end else if (i_bus_req) begin
            pg_index <= i_frame;                // Request wins over load
        end else if (i_index_we) begin
            pg_index <= i_index_data;
        end
    end

    //--------------------------------------------------
    // Used and dirty arrays
    //--------------------------------------------------
    // Later assignment wins, so request settings override flag writes
    always_ff @(posedge clk) begin
        if (i_flags_we) begin
            pg_used[pg_index]  <= i_flags_data[0];
            pg_dirty[pg_index] <= i_flags_data[1];
        end
        if (i_bus_req) begin
            pg_used[i_frame] <= 1'b1;           // Any access marks used
            if (dirtying) begin
                pg_dirty[i_frame] <= 1'b1;      // Write-type access
            end
        end
    end

    assign o_pg_index = pg_index;
    assign o_access   = {pg_dirty[pg_index], pg_used[pg_index], 1'b0};

endmodule

// ==== rtl/mmu_pkg.sv ====
// MMU shared definitions
// Widths, entry types, modifier-select codes and dirtying bus opcodes
package mmu_pkg;

    //--------------------------------------------------
    // Address geometry
    //--------------------------------------------------
    localparam int PAGE_BITS   = 10;                // Page or frame number
    localparam int OFFSET_BITS = 10;                // Offset inside a page
    localparam int NUM_PAGES   = 1 << PAGE_BITS;    // Map and flag depth

    typedef logic [31:0]                      vaddr_t;      // Effective address word
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] paddr_t;      // Physical address
    typedef logic [PAGE_BITS-1:0]             page_t;       // Page or frame number
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] map_entry_t;  // Frame sits in 19..10

    //--------------------------------------------------
    // Modifier memory
    //--------------------------------------------------
    localparam int MOD_GROUP_BITS = 5;              // Group number width
    localparam int MOD_INDEX_BITS = 5;              // Modifier number width
    localparam int MOD_PRIV_BASE  = 16;             // M16..M31 need privilege

    typedef logic [31:0] mod_word_t;                // Modifier register value

    // Sources of the modifier number
    localparam logic [1:0] MNSA_UREG  = 2'd0;       // Effective address 4..0
    localparam logic [1:0] MNSA_INSTR = 2'd1;       // Instruction modifier field
    localparam logic [1:0] MNSA_NONE  = 2'd2;       // Always M0
    localparam logic [1:0] MNSA_FIELD = 2'd3;       // Inverted microcode field

    //--------------------------------------------------
    // Bus opcodes
    //--------------------------------------------------
    typedef logic [3:0] bus_opc_t;

    // Requests that modify the page, so they mark it dirty
    localparam bus_opc_t OPC_CCWR  = 4'd2;          // Instruction cache write
    localparam bus_opc_t OPC_DCWR  = 4'd4;          // Operand cache write
    localparam bus_opc_t OPC_DWR   = 4'd10;         // Result write
    localparam bus_opc_t OPC_RDMWR = 4'd11;         // Read-modify-write
    localparam bus_opc_t OPC_BTRWR = 4'd12;         // Block transfer write

endpackage

// ==== rtl/mmu_table_ram.sv ====
`timescale 1ns/1ps
// MMU table memory
// 1024 entries, write at the clock edge, asynchronous read.
// Entry type is a parameter so page map and modifiers share it
module mmu_table_ram #(
    parameter type T_ENTRY = logic [31:0]
) (
    input  logic           clk,
    input  logic           i_we,        // Write strobe
    input  mmu_pkg::page_t i_waddr,     // Write address
    input  mmu_pkg::page_t i_raddr,     // Read address
    input  T_ENTRY         i_wdata,     // Write data
    output T_ENTRY         o_rdata      // Read data, combinational
);
    import mmu_pkg::*;

    T_ENTRY mem [NUM_PAGES];            // Storage array, no reset

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];      // Fall-through read

endmodule

// ==== rtl/mmu_top.sv ====
`timescale 1ns/1ps
// MMU top level
// Address translation, page access tracking, reprioritize bits
// and modifier registers
module mmu_top (
    input  logic                               clk,
    input  logic                               reset,

    // Effective address and page map
    input  logic                               i_ureg_we,
    input  mmu_pkg::vaddr_t                    i_ureg_data,
    input  logic                               i_map_we,
    input  mmu_pkg::map_entry_t                i_map_data,
    input  logic                               i_no_paging,
    output mmu_pkg::paddr_t                    o_physad,
    output mmu_pkg::map_entry_t                o_map_entry,

    // Bus requests, page index and flags
    input  logic                               i_bus_req,
    input  mmu_pkg::bus_opc_t                  i_bus_opc,
    input  logic                               i_index_we,
    input  mmu_pkg::page_t                     i_index_data,
    input  logic                               i_flags_we,
    input  logic [1:0]                         i_flags_data,
    output mmu_pkg::page_t                     o_pg_index,
    output logic [2:0]                         o_access,

    // Reprioritize bits
    input  logic                               i_fill_start,
    input  logic                               i_reprio_we,
    input  logic                               i_reprio_bit,
    output logic                               o_reprio,
    output logic                               o_fill_busy,

    // Modifier registers
    input  logic                               i_modgn_we,
    input  logic [mmu_pkg::MOD_GROUP_BITS-1:0] i_modgn,
    input  logic [1:0]                         i_mod_sel,
    input  logic [mmu_pkg::MOD_INDEX_BITS-1:0] i_mod_field,
    input  logic [3:0]                         i_instr_mod,
    input  logic                               i_priv,
    input  logic                               i_mod_we,
    input  mmu_pkg::mod_word_t                 i_mod_wdata,
    output mmu_pkg::mod_word_t                 o_mod_rdata
);
    import mmu_pkg::*;

    vaddr_t ureg;           // Effective address
    page_t  frame;          // Translated frame
    page_t  pg_index;       // Current physical page

    //--------------------------------------------------
    // Translation
    //--------------------------------------------------
    page_translate u_translate (
        .clk         (clk),
        .reset       (reset),
        .i_ureg_we   (i_ureg_we),
        .i_ureg_data (i_ureg_data),
        .i_map_we    (i_map_we),
        .i_map_data  (i_map_data),
        .i_no_paging (i_no_paging),
        .o_ureg      (ureg),
        .o_frame     (frame),
        .o_physad    (o_physad),
        .o_map_entry (o_map_entry)
    );

    //--------------------------------------------------
    // Page tracking
    //--------------------------------------------------
    access_tracker u_tracker (
        .clk          (clk),
        .reset        (reset),
        .i_bus_req    (i_bus_req),
        .i_bus_opc    (i_bus_opc),
        .i_frame      (frame),
        .i_index_we   (i_index_we),
        .i_index_data (i_index_data),
        .i_flags_we   (i_flags_we),
        .i_flags_data (i_flags_data),
        .o_pg_index   (pg_index),
        .o_access     (o_access)
    );

    assign o_pg_index = pg_index;

    reprio_fill u_reprio (
        .clk          (clk),
        .reset        (reset),
        .i_pg_index   (pg_index),
        .i_fill_start (i_fill_start),
        .i_reprio_we  (i_reprio_we),
        .i_reprio_bit (i_reprio_bit),
        .o_reprio     (o_reprio),
        .o_fill_busy  (o_fill_busy)
    );

    //--------------------------------------------------
    // Modifiers
    //--------------------------------------------------
    modifier_bank u_modifiers (
        .clk         (clk),
        .reset       (reset),
        .i_modgn_we  (i_modgn_we),
        .i_modgn     (i_modgn),
        .i_mod_sel   (i_mod_sel),
        .i_mod_field (i_mod_field),
        .i_instr_mod (i_instr_mod),
        .i_ureg_low  (ureg[MOD_INDEX_BITS-1:0]),  // Number from address low bits
        .i_priv      (i_priv),
        .i_mod_we    (i_mod_we),
        .i_mod_wdata (i_mod_wdata),
        .o_mod_rdata (o_mod_rdata)
    );

endmodule

// ==== rtl/modifier_bank.sv ====
`timescale 1ns/1ps
// Modifier register bank
// 32 groups of 32 modifiers; number taken from one of four sources.
// Upper modifiers need privilege and M0 is write-protected
module modifier_bank (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i_modgn_we,     // Load group number
    input  logic [mmu_pkg::MOD_GROUP_BITS-1:0] i_modgn,
    input  logic [1:0]                         i_mod_sel,      // Number source
    input  logic [mmu_pkg::MOD_INDEX_BITS-1:0] i_mod_field,    // Microcode field
    input  logic [3:0]                         i_instr_mod,    // Instruction field
    input  logic [mmu_pkg::MOD_INDEX_BITS-1:0] i_ureg_low,     // Effective address 4..0
    input  logic                               i_priv,         // Privileged access
    input  logic                               i_mod_we,
    input  mmu_pkg::mod_word_t                 i_mod_wdata,
    output mmu_pkg::mod_word_t                 o_mod_rdata
);
    import mmu_pkg::*;

    logic [MOD_GROUP_BITS-1:0] modgn;       // Group number register
    logic [MOD_INDEX_BITS-1:0] mn;          // Selected modifier number
    logic                      from_field;  // Field source, always privileged
    logic                      priv_fail;   // Upper modifier without privilege
    logic                      m0_locked;   // M0 from a non-field source
    page_t                     mod_addr;
    mod_word_t                 mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            modgn <= '0;
        end else if (i_modgn_we) begin
            modgn <= i_modgn;
        end
    end

    //--------------------------------------------------
    // Modifier number and protection
    //--------------------------------------------------
    always_comb begin
        case (i_mod_sel)
            MNSA_UREG:  mn = i_ureg_low;
            MNSA_INSTR: mn = MOD_INDEX_BITS'(i_instr_mod);    // Zero-extended
            MNSA_NONE:  mn = '0;
            default:    mn = ~i_mod_field;                     // Field is stored inverted
        endcase
    end

    assign from_field = (i_mod_sel == MNSA_FIELD);
    assign priv_fail  = (mn >= MOD_PRIV_BASE) && !from_field && !i_priv;
    assign m0_locked  = (mn == '0) && !from_field;
    assign mod_addr   = {modgn, mn};

    mmu_table_ram #(
        .T_ENTRY (mod_word_t)
    ) u_mod_mem (
        .clk     (clk),
        .i_we    (i_mod_we && !priv_fail && !m0_locked),
        .i_waddr (mod_addr),
        .i_raddr (mod_addr),
        .i_wdata (i_mod_wdata),
        .o_rdata (mem_rdata)
    );

    assign o_mod_rdata = priv_fail ? '0 : mem_rdata;  // Hidden modifiers read zero

endmodule

// ==== rtl/page_translate.sv ====
`timescale 1ns/1ps
// Page translation
// Effective-address register and page map; turns the virtual page
// into a physical frame unless paging is off
module page_translate (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_ureg_we,      // Load effective address
    input  mmu_pkg::vaddr_t     i_ureg_data,
    input  logic                i_map_we,       // Write map entry of current page
    input  mmu_pkg::map_entry_t i_map_data,
    input  logic                i_no_paging,    // Bypass the map
    output mmu_pkg::vaddr_t     o_ureg,
    output mmu_pkg::page_t      o_frame,        // Translated frame
    output mmu_pkg::paddr_t     o_physad,
    output mmu_pkg::map_entry_t o_map_entry     // Map entry of current page
);
    import mmu_pkg::*;

    vaddr_t     ureg;                           // Effective address register
    page_t      vpage;                          // Virtual page 19..10
    map_entry_t map_rdata;
    page_t      frame;

    //--------------------------------------------------
    // Effective address
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ureg <= '0;
        end else if (i_ureg_we) begin
            ureg <= i_ureg_data;
        end
    end

    assign vpage = ureg[OFFSET_BITS +: PAGE_BITS];

    //--------------------------------------------------
    // Page map
    //--------------------------------------------------
    mmu_table_ram #(
        .T_ENTRY (map_entry_t)
    ) u_map (
        .clk     (clk),
        .i_we    (i_map_we),
        .i_waddr (vpage),                       // Written at the current page
        .i_raddr (vpage),
        .i_wdata (i_map_data),
        .o_rdata (map_rdata)
    );

    // Frame lives in the upper half of the entry
    assign frame = i_no_paging ? vpage : map_rdata[OFFSET_BITS +: PAGE_BITS];

    assign o_ureg      = ureg;
    assign o_frame     = frame;
    assign o_physad    = {frame, ureg[OFFSET_BITS-1:0]};   // Frame plus offset
    assign o_map_entry = map_rdata;

endmodule

// ==== rtl/reprio_fill.sv ====
`timescale 1ns/1ps
// Reprioritize bits
// One bit per page, written singly or swept to ones by the fill
// sequencer from the start index up to the last page
module reprio_fill (
    input  logic           clk,
    input  logic           reset,
    input  mmu_pkg::page_t i_pg_index,      // Current page index
    input  logic           i_fill_start,    // Start a fill at the index
    input  logic           i_reprio_we,     // Single bit write
    input  logic           i_reprio_bit,
    output logic           o_reprio,        // Bit at current index
    output logic           o_fill_busy
);
    import mmu_pkg::*;

    logic [NUM_PAGES-1:0] pg_reprio;        // Reprioritize request bits
    page_t                fill_cnt;         // Next entry to set
    logic                 fill_busy;
    logic                 fill_last;        // Writing the last page

    assign fill_last = (fill_cnt == page_t'(NUM_PAGES - 1));

    //--------------------------------------------------
    // Fill control
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
        end else if (fill_busy) begin
            if (fill_last) begin
                fill_busy <= 1'b0;          // Stop after entry 1023
            end
        end else if (i_fill_start) begin
            fill_busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_busy) begin
            fill_cnt <= fill_cnt + 1'b1;
        end else if (i_fill_start) begin
            fill_cnt <= i_pg_index;         // Sweep begins here
        end
    end

    //--------------------------------------------------
    // Bit array
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_busy) begin
            pg_reprio[fill_cnt] <= 1'b1;    // Single writes locked out
        end else if (i_reprio_we) begin
            pg_reprio[i_pg_index] <= i_reprio_bit;
        end
    end

    assign o_reprio    = pg_reprio[i_pg_index];
    assign o_fill_busy = fill_busy;

endmodule

// ==== sources.f ====
rtl/mmu_pkg.sv
rtl/mmu_table_ram.sv
rtl/page_translate.sv
rtl/access_tracker.sv
rtl/reprio_fill.sv
rtl/modifier_bank.sv
rtl/mmu_top.sv
tests/mmu_props.sv
tests/tb_mmu.sv

// ==== tests/mmu_props.sv ====
`timescale 1ns/1ps
// MMU properties
// Fill busy timing and page index capture on bus requests
module mmu_props (
    input logic           clk,
    input logic           reset,
    input logic           i_bus_req,
    input logic           o_fill_busy,
    input mmu_pkg::page_t o_pg_index,
    input mmu_pkg::page_t frame,        // Translated frame
    input mmu_pkg::page_t fill_cnt      // Fill sequencer position
);
    import mmu_pkg::*;

    // Reset leaves the sequencer idle
    a_idle_after_reset: assert property (@(posedge clk) reset |=> !o_fill_busy)
        else $error("fill busy set in the cycle after reset");

    // Busy drops only once the last page has been written
    a_fill_end: assert property (@(posedge clk) disable iff (reset)
        $fell(o_fill_busy) && !$past(reset) |-> $past(fill_cnt) == page_t'(NUM_PAGES - 1))
        else $error("fill stopped before the last page");

    a_index_capture: assert property (@(posedge clk) disable iff (reset)
        i_bus_req |=> o_pg_index == $past(frame))
        else $error("page index missed the translated frame");

endmodule

bind mmu_top mmu_props u_props (
    .clk         (clk),
    .reset       (reset),
    .i_bus_req   (i_bus_req),
    .o_fill_busy (o_fill_busy),
    .o_pg_index  (o_pg_index),
    .frame       (frame),
    .fill_cnt    (u_reprio.fill_cnt)
);

// ==== tests/tb_mmu.sv ====
`timescale 1ns/1ps
// MMU testbench
// Random strobes against a reference model of the page map, flags,
// reprioritize bits and modifiers; fill runs are timed
module tb_mmu;
    import mmu_pkg::*;

    logic        clk, reset, i_ureg_we, i_map_we, i_no_paging, i_bus_req, i_index_we;
    logic        i_flags_we, i_fill_start, i_reprio_we, i_reprio_bit, o_reprio, o_fill_busy;
    logic        i_modgn_we, i_priv, i_mod_we;
    logic [1:0]  i_flags_data, i_mod_sel;
    logic [2:0]  o_access;
    logic [3:0]  i_instr_mod;
    logic [4:0]  i_modgn, i_mod_field;
    vaddr_t      i_ureg_data;
    map_entry_t  i_map_data, o_map_entry;
    paddr_t      o_physad;
    bus_opc_t    i_bus_opc;
    page_t       i_index_data, o_pg_index;
    mod_word_t   i_mod_wdata, o_mod_rdata;

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    map_entry_t           map_m [NUM_PAGES];
    mod_word_t            mod_m [NUM_PAGES];
    logic [NUM_PAGES-1:0] used_m, dirty_m, rep_m;
    logic [NUM_PAGES-1:0] map_v, flag_v, rep_v, mod_v;   // Entries written so far
    vaddr_t               ureg_m;
    page_t                index_m;
    logic [4:0]           modgn_m;
    logic [31:0]          seed = 32'h90ca;

    mmu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand_word();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic dirtying(input bus_opc_t opc);
        return opc inside {OPC_CCWR, OPC_DCWR, OPC_DWR, OPC_RDMWR, OPC_BTRWR};
    endfunction

    // Modifier number under the current select levels
    function automatic logic [4:0] mod_num(input logic [4:0] ureg_low);
        case (i_mod_sel)
            MNSA_UREG:  return ureg_low;
            MNSA_INSTR: return {1'b0, i_instr_mod};
            MNSA_NONE:  return 5'd0;
            default:    return ~i_mod_field;        // Field arrives inverted
        endcase
    endfunction

    function automatic logic mod_hidden(input logic [4:0] mn);
        return (mn >= MOD_PRIV_BASE) && (i_mod_sel != MNSA_FIELD) && !i_priv;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act));
        end
    endtask

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    task automatic clear_strobes();
        {i_ureg_we, i_map_we, i_bus_req, i_index_we, i_flags_we} <= '0;
        {i_fill_start, i_reprio_we, i_modgn_we, i_mod_we} <= '0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] s;
        r = rand_word();
        s = rand_word();
        {i_ureg_we, i_bus_req, i_mod_we, i_priv, i_mod_sel, i_flags_data} <= r[7:0];
        {i_bus_opc, i_instr_mod, i_reprio_bit} <= r[16:8];
        i_map_we     <= &r[18:17];              // Rarer strobes
        i_index_we   <= &r[20:19];
        i_flags_we   <= &r[22:21];
        i_reprio_we  <= &r[24:23];
        i_modgn_we   <= &r[27:25];
        i_no_paging  <= &r[29:28];
        {i_modgn, i_mod_field, i_index_data} <= s[19:0];
        i_map_data   <= map_entry_t'(rand_word());
        i_ureg_data  <= rand_word();
        i_mod_wdata  <= rand_word();
    endtask

    // Applies the strobes seen at the capture edge, old state first
    task automatic update_model();
        page_t      vpage;
        page_t      frame;
        logic [4:0] mn;
        vpage = ureg_m[19:10];
        frame = i_no_paging ? vpage : map_m[vpage][19:10];
        mn    = mod_num(ureg_m[4:0]);
        if (i_map_we) begin
            map_m[vpage] = i_map_data;
            map_v[vpage] = 1'b1;
        end
        if (i_flags_we) begin
            {dirty_m[index_m], used_m[index_m]} = i_flags_data;
            flag_v[index_m] = 1'b1;
        end
        if (i_bus_req) begin                    // Overrides a flag write
            used_m[frame]  = 1'b1;
            dirty_m[frame] = dirty_m[frame] | dirtying(i_bus_opc);
        end
        if (i_reprio_we) begin
            rep_m[index_m] = i_reprio_bit;
            rep_v[index_m] = 1'b1;
        end
        if (i_mod_we && !mod_hidden(mn) && (mn != 5'd0 || i_mod_sel == MNSA_FIELD)) begin
            mod_m[{modgn_m, mn}] = i_mod_wdata;
            mod_v[{modgn_m, mn}] = 1'b1;
        end
        if (i_bus_req) index_m = frame;         // Request beats index load
        else if (i_index_we) index_m = i_index_data;
        if (i_ureg_we) ureg_m = i_ureg_data;
        if (i_modgn_we) modgn_m = i_modgn;
    endtask

    task automatic check_outputs();
        page_t      vpage;
        logic [4:0] mn;
        logic [9:0] maddr;
        vpage = ureg_m[19:10];
        mn    = mod_num(ureg_m[4:0]);
        maddr = {modgn_m, mn};
        check("o_pg_index", 32'(index_m), 32'(o_pg_index));
        if (i_no_paging) begin
            check("o_physad", 32'(ureg_m[19:0]), 32'(o_physad));
        end else if (map_v[vpage]) begin
            check("o_physad", 32'({map_m[vpage][19:10], ureg_m[9:0]}), 32'(o_physad));
        end
        if (map_v[vpage]) check("o_map_entry", 32'(map_m[vpage]), 32'(o_map_entry));
        if (flag_v[index_m]) begin
            check("o_access", 32'({dirty_m[index_m], used_m[index_m], 1'b0}), 32'(o_access));
        end
        if (rep_v[index_m]) check("o_reprio", 32'(rep_m[index_m]), 32'(o_reprio));
        if (mod_hidden(mn)) check("o_mod_rdata", 32'd0, o_mod_rdata);
        else if (mod_v[maddr]) check("o_mod_rdata", mod_m[maddr], o_mod_rdata);
    endtask

    // Inputs already driven at this edge; capture at the next one
    task automatic run_op();
        @(posedge clk);
        update_model();
        clear_strobes();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic load_index(input page_t idx);
        @(posedge clk);
        i_index_we   <= 1'b1;
        i_index_data <= idx;
        run_op();
    endtask

    // Fill from start up to the last page, with a locked-out write inside
    task automatic run_fill(input page_t start);
        int cycles;
        load_index(start);
        @(posedge clk);
        i_fill_start <= 1'b1;
        @(posedge clk);
        i_fill_start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (o_fill_busy === 1'b1) begin
            cycles++;
            if (cycles > 2 * NUM_PAGES) fail_run("Fill sequencer never dropped busy");
            @(posedge clk);
            i_reprio_we  <= (cycles == 1);      // Clears the start bit if not gated
            i_reprio_bit <= 1'b0;
            @(negedge clk);
        end
        check("fill cycles", 32'(NUM_PAGES) - 32'(start), 32'(cycles));
        for (int i = int'(start); i < NUM_PAGES; i++) begin
            rep_m[i] = 1'b1;
            rep_v[i] = 1'b1;
        end
    endtask

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        logic [31:0] r;
        {map_v, flag_v, rep_v, mod_v} = '0;
        ureg_m  = '0;
        index_m = '0;
        modgn_m = '0;
        reset   = 1'b1;
        drive_random();
        clear_strobes();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("o_fill_busy", 32'd0, 32'(o_fill_busy));
        check_outputs();

        // Map and flags of each page written one op behind its address
        for (int p = 0; p <= NUM_PAGES; p++) begin
            r = rand_word();
            @(posedge clk);
            i_ureg_we    <= 1'b1;
            i_ureg_data  <= {r[31:20], p[9:0], r[9:0]};
            i_index_we   <= 1'b1;
            i_index_data <= p[9:0];
            i_map_we     <= 1'b1;
            i_map_data   <= {r[29:10] ^ r[19:0]};
            i_flags_we   <= 1'b1;
            i_flags_data <= r[11:10];
            i_no_paging  <= r[12];
            run_op();
        end
        run_fill(page_t'(0));

        repeat (3000) begin                     // Mixed random traffic
            @(posedge clk);
            drive_random();
            run_op();
        end

        r = rand_word();
        run_fill(page_t'(r % 1000));
        for (int p = 0; p < NUM_PAGES; p++) load_index(page_t'(p));

        $display("*** PASSED ***");
        $finish;
    end

endmodule
